// File: files.f
common/mul_pkg.sv
rtl/booth_r4_encoder.sv
wallace/csa_level.sv
wallace/wallace_tree.sv
rtl/mul_ctrl.sv
rtl/booth_wallace_mul.sv
verification/tb_clk_gen.sv
verification/mul_assert.sv
verification/tb_booth_wallace_mul.sv

// File: Bender.yml
package:
  name: booth_wallace_mul

sources:
  - common/mul_pkg.sv
  - rtl/booth_r4_encoder.sv
  - wallace/csa_level.sv
  - wallace/wallace_tree.sv
  - rtl/mul_ctrl.sv
  - rtl/booth_wallace_mul.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/mul_assert.sv
      - verification/tb_booth_wallace_mul.sv

// File: verification/tb_booth_wallace_mul.sv
`timescale 1ns/1ps
`default_nettype none

module tb_booth_wallace_mul;

  localparam int xlen = mul_pkg::xlen_default;
  localparam int pw = 2 * xlen;
  localparam int lat = mul_pkg::pipe_latency;
  localparam int done_wait_max = 10;
  localparam int n_random = 50;
  // about 170 operations of 6 cycles each, with margin
  localparam int max_cycles = 2000;
  localparam logic [xlen-1:0] ones = '1;
  localparam logic [xlen-1:0] one = xlen'(1);
  localparam logic [xlen-1:0] min_neg = {1'b1, {(xlen - 1){1'b0}}};

  logic            clk;
  logic            rst;
  logic            req;
  logic            rs1_signed;
  logic            rs2_signed;
  logic [xlen-1:0] rs1;
  logic [xlen-1:0] rs2;
  logic            done;
  logic [pw-1:0]   product;
  int              cycle_cnt = 0;

  tb_clk_gen #(
    .period_ns  (20),
    .rst_cycles (3)
  ) u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  booth_wallace_mul #(
    .XLEN (xlen)
  ) dut_i (
    .clk          (clk),
    .rst          (rst),
    .req_i        (req),
    .rs1_signed_i (rs1_signed),
    .rs2_signed_i (rs2_signed),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .done_o       (done),
    .product_o    (product)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("simulation ran past %0d cycles without finishing", max_cycles);
      $display("TEST FAIL");
      $fatal(1);
    end
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_product(input logic [pw-1:0] got, input logic [pw-1:0] exp,
                               input string what);
    if (got !== exp) begin
      stop_run($sformatf("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                         $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("CHECK FAILED at %0t ns: %s, got %b, expected %b",
                         $time, what, got, exp));
    end
  endtask

  // inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  function automatic logic [xlen-1:0] rand_word();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[xlen-1:0];
  endfunction

  // exact product, each operand read by its own flag
  function automatic logic [pw-1:0] expected_product(input logic [xlen-1:0] a,
                                                     input logic [xlen-1:0] b,
                                                     input logic a_signed,
                                                     input logic b_signed);
    logic [pw-1:0] ea;
    logic [pw-1:0] eb;
    ea = {{xlen{a_signed & a[xlen-1]}}, a};
    eb = {{xlen{b_signed & b[xlen-1]}}, b};
    return ea * eb;
  endfunction

  task automatic drive_operands(input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                                input logic a_signed, input logic b_signed);
    rs1 = a;
    rs2 = b;
    rs1_signed = a_signed;
    rs2_signed = b_signed;
  endtask

  // counts edges, the accepting edge included
  task automatic wait_done(output int cycles);
    cycles = 0;
    do begin
      next_cycle();
      cycles++;
    end while (!done && cycles < done_wait_max);
    if (!done) begin
      stop_run($sformatf("done_o did not arrive within %0d cycles at %0t ns",
                         done_wait_max, $time));
    end
  endtask

  task automatic multiply_once(input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                               input logic a_signed, input logic b_signed);
    logic [pw-1:0] exp;
    int            cycles;
    string         what;
    exp = expected_product(a, b, a_signed, b_signed);
    what = $sformatf("%h(%b) x %h(%b)", a, a_signed, b, b_signed);
    drive_operands(a, b, a_signed, b_signed);
    req = 1'b1;
    wait_done(cycles);
    // accepting edge plus the pipeline latency
    check_flag(cycles == lat + 1, 1'b1, {what, ", done 4 cycles after accept"});
    check_product(product, exp, what);
    req = 1'b0;
    next_cycle();
    check_flag(done, 1'b0, {what, ", done pulse width"});
    check_product(product, exp, {what, ", product held after done"});
  endtask

  task automatic reset_values();
    check_flag(done, 1'b0, "done after reset");
    check_product(product, '0, "product after reset");
  endtask

  task automatic unsigned_products();
    multiply_once(ones, ones, 1'b0, 1'b0);
    multiply_once('0, rand_word(), 1'b0, 1'b0);
    multiply_once(rand_word(), '0, 1'b0, 1'b0);
    for (int i = 0; i < n_random; i++) begin
      multiply_once(rand_word(), rand_word(), 1'b0, 1'b0);
    end
  endtask

  task automatic signed_products();
    multiply_once(min_neg, min_neg, 1'b1, 1'b1);
    multiply_once(min_neg, ones, 1'b1, 1'b1);
    multiply_once(ones, min_neg, 1'b1, 1'b1);
    multiply_once(min_neg, one, 1'b1, 1'b1);
    for (int i = 0; i < n_random; i++) begin
      multiply_once(rand_word(), rand_word(), 1'b1, 1'b1);
    end
  endtask

  // rs1 signed, rs2 unsigned as in mulhsu, then the flags swapped
  task automatic mixed_sign_products();
    multiply_once(ones, ones, 1'b1, 1'b0);
    multiply_once(ones, ones, 1'b0, 1'b1);
    multiply_once(min_neg, ones, 1'b1, 1'b0);
    for (int i = 0; i < n_random; i++) begin
      multiply_once(rand_word(), rand_word(), 1'b1, 1'b0);
    end
    for (int i = 0; i < 5; i++) begin
      multiply_once(rand_word(), rand_word(), 1'b0, 1'b1);
    end
  endtask

  task automatic abort_request();
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [pw-1:0]   prev;
    a = rand_word();
    b = rand_word();
    prev = expected_product(a, b, 1'b1, 1'b0);
    multiply_once(a, b, 1'b1, 1'b0);
    drive_operands(rand_word(), rand_word(), 1'b0, 1'b0);
    req = 1'b1;
    repeat (2) begin
      next_cycle();
      check_flag(done, 1'b0, "done before abort");
    end
    req = 1'b0;
    repeat (8) begin
      next_cycle();
      check_flag(done, 1'b0, "done after abort");
    end
    check_product(product, prev, "product kept through abort");
    multiply_once(rand_word(), rand_word(), 1'b1, 1'b1);
  endtask

  task automatic back_to_back();
    logic [xlen-1:0] a_arr [5];
    logic [xlen-1:0] b_arr [5];
    logic [pw-1:0]   exp_arr [5];
    int              cycles;
    for (int k = 0; k < 5; k++) begin
      a_arr[k] = rand_word();
      b_arr[k] = rand_word();
      exp_arr[k] = expected_product(a_arr[k], b_arr[k], k[0], k[1]);
    end
    drive_operands(a_arr[0], b_arr[0], 1'b0, 1'b0);
    req = 1'b1;
    for (int k = 0; k < 5; k++) begin
      wait_done(cycles);
      // first op counts from the raise, later ones from the previous done
      check_flag(cycles == lat + 1, 1'b1,
                 $sformatf("back-to-back op %0d done spacing", k));
      check_product(product, exp_arr[k], $sformatf("back-to-back op %0d", k));
      // new operands in the done cycle, accepted at the next edge
      if (k < 4) begin
        drive_operands(a_arr[k+1], b_arr[k+1], k[0] ^ 1'b1, (k + 1) >= 2 && (k + 1) != 4);
      end else begin
        req = 1'b0;
      end
    end
    next_cycle();
    check_flag(done, 1'b0, "done after last back-to-back op");
  endtask

  initial begin
    req = 1'b0;
    rs1_signed = 1'b0;
    rs2_signed = 1'b0;
    rs1 = '0;
    rs2 = '0;
    void'($urandom(32'hfd484268));
    @(negedge rst);
    next_cycle();
    reset_values();
    unsigned_products();
    signed_products();
    mixed_sign_products();
    abort_request();
    back_to_back();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/mul_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mul_assert #(
  parameter int lat = mul_pkg::pipe_latency
) (
  input wire logic clk,
  input wire logic rst,
  input wire logic req_i,
  input wire logic done_o
);

  // done is a single-cycle pulse
  done_single_a: assert property (@(posedge clk) disable iff (rst)
    done_o |=> !done_o)
    else $error("done_o was high on two cycles in a row");

  done_needs_req_a: assert property (@(posedge clk) disable iff (rst)
    done_o |-> $past(req_i))
    else $error("done_o rose although req_i was low on the previous cycle");

  // the request must have been held through the whole pipeline
  done_after_pipe_a: assert property (@(posedge clk) disable iff (rst)
    done_o |-> $past(req_i, lat))
    else $error("done_o rose without req_i held through the pipeline");

  done_low_after_rst_a: assert property (@(posedge clk)
    rst |=> !done_o)
    else $error("done_o was high in the cycle after reset");

endmodule

bind booth_wallace_mul mul_assert u_mul_assert (
  .clk    (clk),
  .rst    (rst),
  .req_i  (req_i),
  .done_o (done_o)
);

`default_nettype wire

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int period_ns  = 20,
  parameter int rst_cycles = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // reset is released just after an edge so it never races a sample
  initial begin
    rst = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: rtl/booth_wallace_mul.sv
`timescale 1ns/1ps
`default_nettype none

module booth_wallace_mul #(
  parameter int XLEN = mul_pkg::xlen_default
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              req_i,
  input  wire logic              rs1_signed_i,
  input  wire logic              rs2_signed_i,
  input  wire logic [XLEN-1:0]   rs1_i,
  input  wire logic [XLEN-1:0]   rs2_i,
  output logic                   done_o,
  output logic      [2*XLEN-1:0] product_o
);

  logic [XLEN-1:0]   op_a;
  logic [XLEN-1:0]   op_b;
  logic              op_a_signed;
  logic              op_b_signed;
  logic [2*XLEN-1:0] pp [mul_pkg::pp_rows(XLEN)];
  logic [2*XLEN-1:0] tree_sum;

  mul_ctrl #(
    .XLEN (XLEN)
  ) u_mul_ctrl (
    .clk           (clk),
    .rst           (rst),
    .req_i         (req_i),
    .rs1_signed_i  (rs1_signed_i),
    .rs2_signed_i  (rs2_signed_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .sum_i         (tree_sum),
    .op_a_o        (op_a),
    .op_b_o        (op_b),
    .op_a_signed_o (op_a_signed),
    .op_b_signed_o (op_b_signed),
    .done_o        (done_o),
    .product_o     (product_o)
  );

  // rs1 is the multiplicand, rs2 is booth-recoded
  booth_r4_encoder #(
    .XLEN (XLEN)
  ) u_booth_r4_encoder (
    .op_a_i        (op_a),
    .op_b_i        (op_b),
    .op_a_signed_i (op_a_signed),
    .op_b_signed_i (op_b_signed),
    .pp_o          (pp)
  );

  wallace_tree #(
    .XLEN (XLEN)
  ) u_wallace_tree (
    .clk   (clk),
    .rst   (rst),
    .pp_i  (pp),
    .sum_o (tree_sum)
  );

endmodule

`default_nettype wire

// File: rtl/mul_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mul_ctrl #(
  parameter int XLEN = mul_pkg::xlen_default
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              req_i,
  input  wire logic              rs1_signed_i,
  input  wire logic              rs2_signed_i,
  input  wire logic [XLEN-1:0]   rs1_i,
  input  wire logic [XLEN-1:0]   rs2_i,
  input  wire logic [2*XLEN-1:0] sum_i,
  output logic      [XLEN-1:0]   op_a_o,
  output logic      [XLEN-1:0]   op_b_o,
  output logic                   op_a_signed_o,
  output logic                   op_b_signed_o,
  output logic                   done_o,
  output logic      [2*XLEN-1:0] product_o
);

  localparam int cw = mul_pkg::cnt_w;
  localparam logic [cw-1:0] cnt_last = cw'(mul_pkg::pipe_latency - 1);

  typedef enum logic {
    st_idle,
    st_busy
  } state_t;

  state_t        state_q;
  logic [cw-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= st_idle;
      cnt_q         <= '0;
      done_o        <= 1'b0;
      product_o     <= '0;
      op_a_o        <= '0;
      op_b_o        <= '0;
      op_a_signed_o <= 1'b0;
      op_b_signed_o <= 1'b0;
    end else begin
      // done is a single-cycle pulse
      done_o <= 1'b0;
      case (state_q)
        st_idle: begin
          cnt_q <= '0;
          if (req_i) begin
            state_q       <= st_busy;
            op_a_o        <= rs1_i;
            op_b_o        <= rs2_i;
            op_a_signed_o <= rs1_signed_i;
            op_b_signed_o <= rs2_signed_i;
          end
        end
        st_busy: begin
          if (!req_i) begin
            // aborted, result register keeps the old product
            state_q <= st_idle;
          end else begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == cnt_last) begin
              product_o <= sum_i;
              done_o    <= 1'b1;
              state_q   <= st_idle;
            end
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: wallace/wallace_tree.sv
`timescale 1ns/1ps
`default_nettype none

module wallace_tree #(
  parameter int XLEN = mul_pkg::xlen_default
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic [2*XLEN-1:0] pp_i [mul_pkg::pp_rows(XLEN)],
  output logic      [2*XLEN-1:0] sum_o
);

  // row count entering a given level
  function automatic int rows_at(int lvl);
    int n;
    n = mul_pkg::pp_rows(XLEN);
    for (int i = 0; i < lvl; i++) begin
      n = mul_pkg::csa_rows_out(n);
    end
    return n;
  endfunction

  localparam int pw = 2 * XLEN;
  localparam int n_rows = mul_pkg::pp_rows(XLEN);
  localparam int n_levels = mul_pkg::tree_levels(n_rows);
  localparam int reg_lvl = mul_pkg::reg_after_level;
  localparam int mid_rows = rows_at(reg_lvl);

  logic [pw-1:0] pp_q  [n_rows];
  logic [pw-1:0] mid_q [mid_rows];
  logic [pw-1:0] fin_a_q;
  logic [pw-1:0] fin_b_q;

  // stage 1: partial products straight from the encoder
  always_ff @(posedge clk) begin
    if (rst) begin
      pp_q <= '{default: '0};
    end else begin
      pp_q <= pp_i;
    end
  end

  for (genvar k = 0; k < n_levels; k++) begin : g_lvl
    localparam int rin = rows_at(k);
    localparam int rout = mul_pkg::csa_rows_out(rin);

    logic [pw-1:0] lvl_in  [rin];
    logic [pw-1:0] lvl_out [rout];

    for (genvar r = 0; r < rin; r++) begin : g_in
      if (k == 0) begin : g_first
        assign lvl_in[r] = pp_q[r];
      end else if (k == reg_lvl) begin : g_mid
        assign lvl_in[r] = mid_q[r];
      end else begin : g_chain
        assign lvl_in[r] = g_lvl[k-1].lvl_out[r];
      end
    end

    csa_level #(
      .XLEN    (XLEN),
      .ROWS_IN (rin)
    ) u_csa_level (
      .rows_i (lvl_in),
      .rows_o (lvl_out)
    );
  end

  // stage 2: cut the tree behind the fourth level
  always_ff @(posedge clk) begin
    if (rst) begin
      mid_q <= '{default: '0};
    end else begin
      mid_q <= g_lvl[reg_lvl-1].lvl_out;
    end
  end

  // stage 3: last sum/carry pair
  always_ff @(posedge clk) begin
    if (rst) begin
      fin_a_q <= '0;
      fin_b_q <= '0;
    end else begin
      fin_a_q <= g_lvl[n_levels-1].lvl_out[0];
      fin_b_q <= g_lvl[n_levels-1].lvl_out[1];
    end
  end

  // carry-propagate add, overflow past 2*XLEN is dropped
  assign sum_o = fin_a_q + fin_b_q;

endmodule

`default_nettype wire

// File: wallace/csa_level.sv
`timescale 1ns/1ps
`default_nettype none

module csa_level #(
  parameter int XLEN    = mul_pkg::xlen_default,
  parameter int ROWS_IN = 3
) (
  input  wire logic [2*XLEN-1:0] rows_i [ROWS_IN],
  output logic      [2*XLEN-1:0] rows_o [mul_pkg::csa_rows_out(ROWS_IN)]
);

  localparam int pw = 2 * XLEN;
  localparam int n_groups = ROWS_IN / 3;
  localparam int n_left = ROWS_IN % 3;

  for (genvar g = 0; g < n_groups; g++) begin : g_csa
    logic [pw-1:0] a;
    logic [pw-1:0] b;
    logic [pw-1:0] c;
    logic [pw-1:0] sum;
    logic [pw-1:0] carry;

    assign a = rows_i[3*g];
    assign b = rows_i[3*g+1];
    assign c = rows_i[3*g+2];

    // full adder on every bit column
    assign sum = a ^ b ^ c;
    assign carry = (a & b) | (a & c) | (b & c);

    assign rows_o[2*g] = sum;
    // carry moves one column up, the top carry falls off the product width
    assign rows_o[2*g+1] = {carry[pw-2:0], 1'b0};
  end

  // rows that do not fill a group go straight through
  for (genvar l = 0; l < n_left; l++) begin : g_pass
    assign rows_o[2*n_groups+l] = rows_i[3*n_groups+l];
  end

endmodule

`default_nettype wire

// File: rtl/booth_r4_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module booth_r4_encoder #(
  parameter int XLEN = mul_pkg::xlen_default
) (
  input  wire logic [XLEN-1:0]   op_a_i,
  input  wire logic [XLEN-1:0]   op_b_i,
  input  wire logic              op_a_signed_i,
  input  wire logic              op_b_signed_i,
  output logic      [2*XLEN-1:0] pp_o [mul_pkg::pp_rows(XLEN)]
);

  localparam int pw = 2 * XLEN;
  localparam int n_rows = mul_pkg::pp_rows(XLEN);

  logic          a_sign;
  logic          b_sign;
  logic [pw-1:0] a_x1;
  logic [pw-1:0] a_x2;
  // multiplier with two extension bits on top and the implicit zero below
  logic [XLEN+2:0] b_win;

  assign a_sign = op_a_signed_i & op_a_i[XLEN-1];
  assign b_sign = op_b_signed_i & op_b_i[XLEN-1];

  // multiplicand extended to the full product width
  assign a_x1 = {{XLEN{a_sign}}, op_a_i};
  assign a_x2 = {a_x1[pw-2:0], 1'b0};

  assign b_win = {{2{b_sign}}, op_b_i, 1'b0};

  for (genvar i = 0; i < n_rows; i++) begin : g_row
    logic [2:0]    win;
    logic [pw-1:0] mag;
    logic [pw-1:0] row;

    // overlapping window b[2i+1], b[2i], b[2i-1]
    assign win = b_win[2*i+2 -: 3];

    always_comb begin
      case (win)
        3'b001, 3'b010, 3'b101, 3'b110: begin
          mag = a_x1;
        end
        3'b011, 3'b100: begin
          mag = a_x2;
        end
        default: begin
          mag = '0;
        end
      endcase
    end

    // negative digits: two's complement inside the row
    // 3'b111 gives ~0 + 1, which wraps back to zero
    assign row = win[2] ? (~mag + 1'b1) : mag;

    // weight of row i is 4^i
    assign pp_o[i] = row << (2 * i);
  end

endmodule

`default_nettype wire

// File: common/mul_pkg.sv
`default_nettype none

package mul_pkg;

  // operand width used when the top level is not overridden
  localparam int xlen_default = 64;

  // radix-4 booth rows, one extra window for the unsigned case
  function automatic int pp_rows(int xlen);
    return xlen / 2 + 1;
  endfunction

  // rows left after one 3:2 level, leftovers pass through
  function automatic int csa_rows_out(int rows_in);
    return (rows_in / 3) * 2 + rows_in % 3;
  endfunction

  // levels needed to bring a row set down to a sum/carry pair
  function automatic int tree_levels(int rows_in);
    int n;
    int lvl;
    n = rows_in;
    lvl = 0;
    while (n > 2) begin
      n = csa_rows_out(n);
      lvl++;
    end
    return lvl;
  endfunction

  // middle tree register sits behind the fourth level
  localparam int reg_after_level = 4;

  // capture to result, in clock edges
  localparam int pipe_latency = 4;
  localparam int cnt_w = $clog2(pipe_latency);

endpackage

`default_nettype wire
